// File: source/mem_subsys_pkg.sv
package mem_subsys_pkg;

    // byte address on the generic bus
    typedef logic [31:0] addr_t;

    // one bus word, four byte lanes
    typedef logic [31:0] word_t;

    // instruction fetch request
    // always a full-word read, so only the address travels
    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    // data request from the dcache port
    // 69 bits in total
    typedef struct packed {
        // target byte address
        addr_t      addr;
        // write data, ignored on reads
        word_t      wdata;
        // lane 0 is bits 7:0
        logic [3:0] byte_en;
        // set for a write
        logic       wen;
    } data_req_t;

    // response back to a front-side port
    // shared shape for fetch and data replies
    typedef struct packed {
        // read data, undefined after a write
        word_t rdata;
        // bus reported an error for this access
        logic  error;
    } mem_resp_t;

endpackage

// File: source/port_arbiter.sv
`timescale 1ns/1ps

module port_arbiter #(
    parameter int  NUM_PORTS = 2,
    parameter int  CREDITS   = 2,
    parameter type payload_t = logic [31:0]
) (
    input  logic                                              CLK,
    input  logic                                              rst,
    // front side, requester only sends while holding a credit
    input  logic [NUM_PORTS-1:0]                              in_valid,
    input  payload_t                                          in_payload [NUM_PORTS],
    output logic [NUM_PORTS-1:0]                              credit,
    // towards the memory controller
    output logic                                              out_valid,
    output payload_t                                          out_payload,
    output logic [(NUM_PORTS > 1 ? $clog2(NUM_PORTS) : 1)-1:0] out_port,
    input  logic                                              out_ready
);
    localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int PTR_W  = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W  = $clog2(CREDITS + 1);

    // one circular buffer per port, depth equals the credit count
    payload_t          slots  [NUM_PORTS][CREDITS];
    logic [PTR_W-1:0]  wr_ptr [NUM_PORTS];
    logic [PTR_W-1:0]  rd_ptr [NUM_PORTS];
    logic [CNT_W-1:0]  count  [NUM_PORTS];
    logic [NUM_PORTS-1:0] not_empty;
    logic [NUM_PORTS-1:0] pop;

    // round-robin state
    logic [PORT_W-1:0] last_port;
    logic [PORT_W-1:0] held_port;
    logic              locked;
    logic [PORT_W-1:0] pick;
    logic              pick_valid;
    logic              xfer;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        // wrap at the last slot
        if (ptr == PTR_W'(CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign xfer = out_valid && out_ready;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        assign not_empty[p] = (count[p] != '0);
        // entry leaves only when this port is the offered one
        assign pop[p] = xfer && (pick == PORT_W'(p));

        // requester must never send without a free slot
        a_no_overflow: assert property (@(posedge CLK) disable iff (rst)
            in_valid[p] |-> (count[p] != CNT_W'(CREDITS)));
    end

    // payload storage
    always_ff @(posedge CLK) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (in_valid[p]) begin
                slots[p][wr_ptr[p]] <= in_payload[p];
            end
        end
    end

    // pointers, fill level and credit return
    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                count[p]  <= '0;
            end
            credit <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (in_valid[p]) begin
                    wr_ptr[p] <= next_ptr(wr_ptr[p]);
                end
                if (pop[p]) begin
                    rd_ptr[p] <= next_ptr(rd_ptr[p]);
                end
                count[p] <= count[p] + CNT_W'(in_valid[p]) - CNT_W'(pop[p]);
            end
            // credit pulse one cycle after the entry leaves
            credit <= pop;
        end
    end

    // search starts after the last port served
    // a stalled offer stays locked until it transfers
    always_comb begin
        int idx;
        idx        = 0;
        pick       = held_port;
        pick_valid = locked;
        if (!locked) begin
            for (int i = 1; i <= NUM_PORTS; i++) begin
                idx = int'(last_port) + i;
                if (idx >= NUM_PORTS) begin
                    idx = idx - NUM_PORTS;
                end
                if (!pick_valid && not_empty[idx]) begin
                    pick       = PORT_W'(idx);
                    pick_valid = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            locked    <= 1'b0;
            held_port <= '0;
            // port 0 gets the first turn
            last_port <= PORT_W'(NUM_PORTS - 1);
        end else if (xfer) begin
            locked    <= 1'b0;
            last_port <= pick;
        end else if (out_valid) begin
            locked    <= 1'b1;
            held_port <= pick;
        end
    end

    assign out_valid   = pick_valid;
    assign out_port    = pick;
    // oldest entry of the chosen port
    assign out_payload = slots[pick][rd_ptr[pick]];

    // offer holds while the controller stalls
    a_offer_stable: assert property (@(posedge CLK) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_payload) && $stable(out_port));

endmodule

// File: source/memory_controller.sv
`timescale 1ns/1ps

module memory_controller #(
    parameter int NUM_HARTS = 2
) (
    input  logic                                              CLK,
    input  logic                                              rst,
    // fetch arbiter winner
    input  logic                                              fetch_valid,
    input  mem_subsys_pkg::fetch_req_t                        fetch_payload,
    input  logic [(NUM_HARTS > 1 ? $clog2(NUM_HARTS) : 1)-1:0] fetch_port,
    output logic                                              fetch_ready,
    // data arbiter winner
    input  logic                                              data_valid,
    input  mem_subsys_pkg::data_req_t                         data_payload,
    input  logic [(NUM_HARTS > 1 ? $clog2(NUM_HARTS) : 1)-1:0] data_port,
    output logic                                              data_ready,
    // towards the bus master
    output logic                                              issue_valid,
    output mem_subsys_pkg::addr_t                             issue_addr,
    output mem_subsys_pkg::word_t                             issue_wdata,
    output logic [3:0]                                        issue_byte_en,
    output logic                                              issue_wen,
    input  logic                                              done,
    input  mem_subsys_pkg::mem_resp_t                         result,
    // responses back to the ports
    output logic [NUM_HARTS-1:0]                              fetch_resp_valid,
    output logic [NUM_HARTS-1:0]                              data_resp_valid,
    output mem_subsys_pkg::mem_resp_t                         fetch_resp,
    output mem_subsys_pkg::mem_resp_t                         data_resp
);
    localparam int PORT_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1;

    // transaction outstanding at the bus master
    logic              open;
    logic              open_data;
    logic [PORT_W-1:0] open_port;
    // kind of the last accepted winner, set means data
    logic              served_data;
    logic              take_fetch;
    logic              take_data;

    // one winner per idle slot, the kind not served last wins a tie
    assign fetch_ready = !open && fetch_valid && (!data_valid || served_data);
    assign data_ready  = !open && data_valid && (!fetch_valid || !served_data);
    assign take_fetch  = fetch_valid && fetch_ready;
    assign take_data   = data_valid && data_ready;
    assign issue_valid = take_fetch || take_data;

    always_comb begin
        if (take_data) begin
            issue_addr    = data_payload.addr;
            issue_wdata   = data_payload.wdata;
            issue_byte_en = data_payload.byte_en;
            issue_wen     = data_payload.wen;
        end else begin
            // fetch is a full-word read
            issue_addr    = fetch_payload.addr;
            issue_wdata   = '0;
            issue_byte_en = 4'hf;
            issue_wen     = 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            open        <= 1'b0;
            open_data   <= 1'b0;
            open_port   <= '0;
            // fetch takes the first tie
            served_data <= 1'b1;
        end else if (issue_valid) begin
            open        <= 1'b1;
            open_data   <= take_data;
            open_port   <= take_data ? data_port : fetch_port;
            served_data <= take_data;
        end else if (done) begin
            open <= 1'b0;
        end
    end

    // route done to the port that asked
    always_comb begin
        fetch_resp_valid = '0;
        data_resp_valid  = '0;
        if (done) begin
            if (open_data) begin
                data_resp_valid[open_port] = 1'b1;
            end else begin
                fetch_resp_valid[open_port] = 1'b1;
            end
        end
    end

    assign fetch_resp = result;
    assign data_resp  = result;

    // bus master only answers what was issued
    a_done_open: assert property (@(posedge CLK) disable iff (rst) done |-> open);

    a_one_ready: assert property (@(posedge CLK) disable iff (rst)
        !(fetch_ready && data_ready));

endmodule

// File: source/generic_bus_master.sv
`timescale 1ns/1ps

module generic_bus_master (
    input  logic                      CLK,
    input  logic                      rst,
    // one request at a time from the controller
    input  logic                      issue_valid,
    input  mem_subsys_pkg::addr_t     issue_addr,
    input  mem_subsys_pkg::word_t     issue_wdata,
    input  logic [3:0]                issue_byte_en,
    input  logic                      issue_wen,
    output logic                      done,
    output mem_subsys_pkg::mem_resp_t result,
    // generic bus
    output mem_subsys_pkg::addr_t     bus_addr,
    output mem_subsys_pkg::word_t     bus_wdata,
    output logic                      bus_ren,
    output logic                      bus_wen,
    output logic [3:0]                bus_byte_en,
    input  mem_subsys_pkg::word_t     bus_rdata,
    input  logic                      bus_busy,
    input  logic                      bus_error
);
    // registered copy of the request on the bus
    mem_subsys_pkg::data_req_t req_q;
    logic                      held;
    logic                      finish;

    assign held   = bus_ren || bus_wen;
    // completing cycle, strobe up and busy low
    assign finish = held && !bus_busy;

    always_ff @(posedge CLK) begin
        if (issue_valid) begin
            req_q <= '{addr: issue_addr, wdata: issue_wdata,
                       byte_en: issue_byte_en, wen: issue_wen};
        end
        if (finish) begin
            result <= '{rdata: bus_rdata, error: bus_error};
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            bus_ren <= 1'b0;
            bus_wen <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= finish;
            if (issue_valid) begin
                bus_ren <= !issue_wen;
                bus_wen <= issue_wen;
            end else if (finish) begin
                bus_ren <= 1'b0;
                bus_wen <= 1'b0;
            end
        end
    end

    assign bus_addr    = req_q.addr;
    assign bus_wdata   = req_q.wdata;
    assign bus_byte_en = req_q.byte_en;

    // slave may sample the address late
    a_addr_hold: assert property (@(posedge CLK) disable iff (rst)
        held && bus_busy |=> $stable(bus_addr));

endmodule

// File: source/multicore_mem_top.sv
`timescale 1ns/1ps

module multicore_mem_top #(
    parameter int NUM_HARTS = 2,
    parameter int CREDITS   = 2
) (
    input  logic                       CLK,
    input  logic                       rst,
    // icache ports, one per hart
    input  logic [NUM_HARTS-1:0]       fetch_req_valid,
    input  mem_subsys_pkg::fetch_req_t fetch_req [NUM_HARTS],
    output logic [NUM_HARTS-1:0]       fetch_credit,
    output logic [NUM_HARTS-1:0]       fetch_resp_valid,
    output mem_subsys_pkg::mem_resp_t  fetch_resp,
    // dcache ports, one per hart
    input  logic [NUM_HARTS-1:0]       data_req_valid,
    input  mem_subsys_pkg::data_req_t  data_req [NUM_HARTS],
    output logic [NUM_HARTS-1:0]       data_credit,
    output logic [NUM_HARTS-1:0]       data_resp_valid,
    output mem_subsys_pkg::mem_resp_t  data_resp,
    // generic bus towards memory
    output mem_subsys_pkg::addr_t      bus_addr,
    output mem_subsys_pkg::word_t      bus_wdata,
    output logic                       bus_ren,
    output logic                       bus_wen,
    output logic [3:0]                 bus_byte_en,
    input  mem_subsys_pkg::word_t      bus_rdata,
    input  logic                       bus_busy,
    input  logic                       bus_error
);
    localparam int PORT_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1;

    // fetch arbiter to controller
    logic                       fetch_valid;
    logic                       fetch_ready;
    mem_subsys_pkg::fetch_req_t fetch_payload;
    logic [PORT_W-1:0]          fetch_port;

    // data arbiter to controller
    logic                       data_valid;
    logic                       data_ready;
    mem_subsys_pkg::data_req_t  data_payload;
    logic [PORT_W-1:0]          data_port;

    // controller to bus master
    logic                       issue_valid;
    mem_subsys_pkg::addr_t      issue_addr;
    mem_subsys_pkg::word_t      issue_wdata;
    logic [3:0]                 issue_byte_en;
    logic                       issue_wen;
    logic                       done;
    mem_subsys_pkg::mem_resp_t  result;

    port_arbiter #(
        .NUM_PORTS(NUM_HARTS),
        .CREDITS(CREDITS),
        .payload_t(mem_subsys_pkg::fetch_req_t)
    ) fetch_arb (
        .CLK(CLK),
        .rst(rst),
        .in_valid(fetch_req_valid),
        .in_payload(fetch_req),
        .credit(fetch_credit),
        .out_valid(fetch_valid),
        .out_payload(fetch_payload),
        .out_port(fetch_port),
        .out_ready(fetch_ready)
    );

    port_arbiter #(
        .NUM_PORTS(NUM_HARTS),
        .CREDITS(CREDITS),
        .payload_t(mem_subsys_pkg::data_req_t)
    ) data_arb (
        .CLK(CLK),
        .rst(rst),
        .in_valid(data_req_valid),
        .in_payload(data_req),
        .credit(data_credit),
        .out_valid(data_valid),
        .out_payload(data_payload),
        .out_port(data_port),
        .out_ready(data_ready)
    );

    memory_controller #(
        .NUM_HARTS(NUM_HARTS)
    ) mc (
        .CLK(CLK),
        .rst(rst),
        .fetch_valid(fetch_valid),
        .fetch_payload(fetch_payload),
        .fetch_port(fetch_port),
        .fetch_ready(fetch_ready),
        .data_valid(data_valid),
        .data_payload(data_payload),
        .data_port(data_port),
        .data_ready(data_ready),
        .issue_valid(issue_valid),
        .issue_addr(issue_addr),
        .issue_wdata(issue_wdata),
        .issue_byte_en(issue_byte_en),
        .issue_wen(issue_wen),
        .done(done),
        .result(result),
        .fetch_resp_valid(fetch_resp_valid),
        .data_resp_valid(data_resp_valid),
        .fetch_resp(fetch_resp),
        .data_resp(data_resp)
    );

    generic_bus_master bm (
        .CLK(CLK),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue_addr(issue_addr),
        .issue_wdata(issue_wdata),
        .issue_byte_en(issue_byte_en),
        .issue_wen(issue_wen),
        .done(done),
        .result(result),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_ren(bus_ren),
        .bus_wen(bus_wen),
        .bus_byte_en(bus_byte_en),
        .bus_rdata(bus_rdata),
        .bus_busy(bus_busy),
        .bus_error(bus_error)
    );

endmodule

// File: verification/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter int          WORDS      = 256,
    parameter logic [31:0] ERROR_BASE = 32'h0000_0300,
    parameter logic [31:0] ERROR_SIZE = 32'h0000_0040,
    parameter logic [31:0] SEED       = 32'h7332_4137
) (
    input  logic                  CLK,
    input  logic                  rst,
    // test controls, hold stalls every access
    input  logic                  hold,
    input  logic                  rand_busy,
    // generic bus, slave side
    input  mem_subsys_pkg::addr_t bus_addr,
    input  mem_subsys_pkg::word_t bus_wdata,
    input  logic                  bus_ren,
    input  logic                  bus_wen,
    input  logic [3:0]            bus_byte_en,
    output mem_subsys_pkg::word_t bus_rdata,
    output logic                  bus_busy,
    output logic                  bus_error
);
    localparam int IDX_W = $clog2(WORDS);

    mem_subsys_pkg::word_t mem [WORDS];
    logic [IDX_W-1:0]      idx;
    logic                  strobe;
    logic                  active;
    logic                  in_window;
    logic [2:0]            wait_cnt;
    integer                seed;

    assign idx       = bus_addr[IDX_W+1:2];
    assign strobe    = bus_ren || bus_wen;
    assign in_window = (bus_addr >= ERROR_BASE) && (bus_addr < ERROR_BASE + ERROR_SIZE);
    // first cycle of an access is always a wait state
    assign bus_busy  = strobe && (hold || !active || (wait_cnt != '0));
    assign bus_error = strobe && in_window;
    // read data only on reads, zero for a faulted read
    assign bus_rdata = (bus_ren && !in_window) ? mem[idx] : '0;

    initial begin
        logic [15:0] a;
        seed = SEED;
        // word holds its own byte address, upper half inverted
        for (int i = 0; i < WORDS; i++) begin
            a = 16'(i * 4);
            mem[i] = {~a, a};
        end
    end

    always @(posedge CLK) begin
        if (rst) begin
            active   <= 1'b0;
            wait_cnt <= '0;
        end else if (strobe && !active) begin
            active   <= 1'b1;
            // 0 to 4 extra wait states
            wait_cnt <= rand_busy ? 3'($unsigned($random(seed)) % 5) : '0;
        end else if (strobe && !bus_busy) begin
            active <= 1'b0;
            // writes into the error window are dropped
            if (bus_wen && !in_window) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_byte_en[b]) begin
                        mem[idx][8*b +: 8] = bus_wdata[8*b +: 8];
                    end
                end
            end
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

endmodule

// File: verification/tb_multicore_mem.sv
`timescale 1ns/1ps

module tb_multicore_mem;
    localparam int NUM_HARTS = 2;
    localparam int CREDITS   = 2;
    // error window handed to the memory model
    localparam logic [31:0] WIN_BASE = 32'h0000_0300;
    localparam logic [31:0] WIN_SIZE = 32'h0000_0040;
    // single 2, byte lanes 2, flood 8, arbitration 8, error 2
    localparam int TOTAL_REQS      = 22;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 200;

    logic                      CLK;
    logic                      rst;
    logic [NUM_HARTS-1:0]      fetch_req_valid;
    mem_subsys_pkg::fetch_req_t fetch_req [NUM_HARTS];
    logic [NUM_HARTS-1:0]      fetch_credit;
    logic [NUM_HARTS-1:0]      fetch_resp_valid;
    mem_subsys_pkg::mem_resp_t fetch_resp;
    logic [NUM_HARTS-1:0]      data_req_valid;
    mem_subsys_pkg::data_req_t data_req [NUM_HARTS];
    logic [NUM_HARTS-1:0]      data_credit;
    logic [NUM_HARTS-1:0]      data_resp_valid;
    mem_subsys_pkg::mem_resp_t data_resp;
    mem_subsys_pkg::addr_t     bus_addr;
    mem_subsys_pkg::word_t     bus_wdata;
    logic                      bus_ren;
    logic                      bus_wen;
    logic [3:0]                bus_byte_en;
    mem_subsys_pkg::word_t     bus_rdata;
    logic                      bus_busy;
    logic                      bus_error;
    logic                      hold;
    logic                      rand_busy;

    // shadow of the model contents
    mem_subsys_pkg::word_t     shadow [256];
    // credits held, spent and returned per port
    int                        fcred [NUM_HARTS];
    int                        dcred [NUM_HARTS];
    int                        fspent [NUM_HARTS];
    int                        dspent [NUM_HARTS];
    int                        fret [NUM_HARTS];
    int                        dret [NUM_HARTS];
    // expected responses per port, oldest first
    mem_subsys_pkg::mem_resp_t fexp [NUM_HARTS][$];
    mem_subsys_pkg::mem_resp_t dexp [NUM_HARTS][$];
    // addresses of completed bus accesses
    mem_subsys_pkg::addr_t     bus_seen [$];
    integer                    seed;

    multicore_mem_top #(
        .NUM_HARTS(NUM_HARTS),
        .CREDITS(CREDITS)
    ) DUT (
        .CLK(CLK),
        .rst(rst),
        .fetch_req_valid(fetch_req_valid),
        .fetch_req(fetch_req),
        .fetch_credit(fetch_credit),
        .fetch_resp_valid(fetch_resp_valid),
        .fetch_resp(fetch_resp),
        .data_req_valid(data_req_valid),
        .data_req(data_req),
        .data_credit(data_credit),
        .data_resp_valid(data_resp_valid),
        .data_resp(data_resp),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_ren(bus_ren),
        .bus_wen(bus_wen),
        .bus_byte_en(bus_byte_en),
        .bus_rdata(bus_rdata),
        .bus_busy(bus_busy),
        .bus_error(bus_error)
    );

    mem_model #(
        .WORDS(256),
        .ERROR_BASE(WIN_BASE),
        .ERROR_SIZE(WIN_SIZE),
        .SEED(32'h7332_4137)
    ) mem_model (
        .CLK(CLK),
        .rst(rst),
        .hold(hold),
        .rand_busy(rand_busy),
        .bus_addr(bus_addr),
        .bus_wdata(bus_wdata),
        .bus_ren(bus_ren),
        .bus_wen(bus_wen),
        .bus_byte_en(bus_byte_en),
        .bus_rdata(bus_rdata),
        .bus_busy(bus_busy),
        .bus_error(bus_error)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_resp(input string name, input mem_subsys_pkg::mem_resp_t got,
                              input mem_subsys_pkg::mem_resp_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input mem_subsys_pkg::addr_t got,
                              input mem_subsys_pkg::addr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_now($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic in_window(input mem_subsys_pkg::addr_t a);
        return (a >= WIN_BASE) && (a < WIN_BASE + WIN_SIZE);
    endfunction

    // faulted reads come back as zero with error set
    function automatic mem_subsys_pkg::mem_resp_t expected_read(input mem_subsys_pkg::addr_t a);
        if (in_window(a)) begin
            return '{rdata: '0, error: 1'b1};
        end
        return '{rdata: shadow[a[9:2]], error: 1'b0};
    endfunction

    function automatic mem_subsys_pkg::word_t merge_lanes(input mem_subsys_pkg::word_t old_w,
                                                          input mem_subsys_pkg::word_t new_w,
                                                          input logic [3:0] be);
        mem_subsys_pkg::word_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return w;
    endfunction

    // arbitration test layout, bit 9 kind, bit 4 port, bit 2 round
    function automatic mem_subsys_pkg::addr_t arb_addr(input int kind, input int h, input int r);
        return 32'h180 + kind * 32'h100 + h * 32'h10 + r * 4;
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            n += fexp[h].size() + dexp[h].size();
        end
        return n;
    endfunction

    // next rising edge, strobes drop unless posted again
    task automatic tick();
        @(posedge CLK);
        fetch_req_valid <= '0;
        data_req_valid  <= '0;
    endtask

    task automatic post_fetch(input int h, input mem_subsys_pkg::addr_t a);
        if (fcred[h] == 0) begin
            fail_now("fetch port has no credit left to send with");
        end
        fcred[h]--;
        fspent[h]++;
        fexp[h].push_back(expected_read(a));
        fetch_req_valid[h] <= 1'b1;
        fetch_req[h]       <= '{addr: a};
    endtask

    task automatic post_data(input int h, input mem_subsys_pkg::addr_t a,
                             input mem_subsys_pkg::word_t wd, input logic [3:0] be,
                             input logic wen);
        if (dcred[h] == 0) begin
            fail_now("data port has no credit left to send with");
        end
        dcred[h]--;
        dspent[h]++;
        if (wen) begin
            // write replies carry no data
            dexp[h].push_back('{rdata: '0, error: in_window(a)});
            if (!in_window(a)) begin
                shadow[a[9:2]] = merge_lanes(shadow[a[9:2]], wd, be);
            end
        end else begin
            dexp[h].push_back(expected_read(a));
        end
        data_req_valid[h] <= 1'b1;
        data_req[h]       <= '{addr: a, wdata: wd, byte_en: be, wen: wen};
    endtask

    // wait for every reply, then every spent credit must be back
    task automatic drain();
        while (outstanding() != 0) begin
            tick();
        end
        for (int h = 0; h < NUM_HARTS; h++) begin
            check_count("fetch_credit", fret[h], fspent[h]);
            check_count("data_credit", dret[h], dspent[h]);
        end
    endtask

    // responses, credits and bus completions sampled mid-cycle
    always @(negedge CLK) begin
        if (!rst) begin
            for (int h = 0; h < NUM_HARTS; h++) begin
                if (fetch_credit[h]) begin
                    fcred[h]++;
                    fret[h]++;
                    if (fcred[h] > CREDITS) begin
                        fail_now("fetch port got more credits back than it spent");
                    end
                end
                if (data_credit[h]) begin
                    dcred[h]++;
                    dret[h]++;
                    if (dcred[h] > CREDITS) begin
                        fail_now("data port got more credits back than it spent");
                    end
                end
                if (fetch_resp_valid[h]) begin
                    if (fexp[h].size() == 0) begin
                        fail_now("fetch response arrived with no request outstanding");
                    end else begin
                        check_resp("fetch_resp", fetch_resp, fexp[h].pop_front());
                    end
                end
                if (data_resp_valid[h]) begin
                    if (dexp[h].size() == 0) begin
                        fail_now("data response arrived with no request outstanding");
                    end else begin
                        check_resp("data_resp", data_resp, dexp[h].pop_front());
                    end
                end
            end
            if ((bus_ren || bus_wen) && !bus_busy) begin
                bus_seen.push_back(bus_addr);
            end
        end
    end

    task automatic reset_quiet();
        repeat (20) begin
            @(negedge CLK);
            if ({fetch_credit, data_credit, fetch_resp_valid, data_resp_valid,
                 bus_ren, bus_wen} !== '0) begin
                fail_now("a strobe went high after reset before any request");
            end
        end
    endtask

    task automatic single_read();
        bus_seen.delete();
        tick();
        post_fetch(0, 32'h10);
        tick();
        drain();
        check_addr("bus_addr", bus_seen[0], 32'h10);
        tick();
        post_data(1, 32'h24, '0, 4'hf, 1'b0);
        tick();
        drain();
        check_addr("bus_addr", bus_seen[1], 32'h24);
    endtask

    task automatic byte_write();
        // lanes 0 and 2 only
        tick();
        post_data(1, 32'h48, 32'ha1b2_c3d4, 4'b0101, 1'b1);
        tick();
        drain();
        tick();
        post_data(1, 32'h48, '0, 4'hf, 1'b0);
        tick();
        drain();
    endtask

    task automatic credit_flood();
        tick();
        rand_busy <= 1'b1;
        for (int r = 0; r < CREDITS; r++) begin
            tick();
            for (int h = 0; h < NUM_HARTS; h++) begin
                post_fetch(h, 32'h100 + h * 32'h20 + r * 4);
                // first round writes, later rounds read
                post_data(h, 32'h200 + h * 32'h20 + r * 4, $random(seed), 4'hf, r == 0);
            end
        end
        tick();
        drain();
        rand_busy <= 1'b0;
    endtask

    task automatic arbitration_order();
        mem_subsys_pkg::addr_t a;
        mem_subsys_pkg::addr_t exp_a;
        int first_port [2];
        bit found [2];
        int served [2];
        int kind0;
        int k;
        bus_seen.delete();
        tick();
        hold <= 1'b1;
        for (int r = 0; r < CREDITS; r++) begin
            tick();
            for (int h = 0; h < NUM_HARTS; h++) begin
                post_fetch(h, arb_addr(0, h, r));
                post_data(h, arb_addr(1, h, r), '0, 4'hf, 1'b0);
            end
        end
        // first access sits on the stalled bus, the rest queue up
        repeat (4) tick();
        hold <= 1'b0;
        drain();
        check_count("bus transfers", bus_seen.size(), 2 * NUM_HARTS * CREDITS);
        // starting kind and ports come from the first of each kind
        found = '{1'b0, 1'b0};
        served = '{0, 0};
        a = bus_seen[0];
        kind0 = int'(a[9]);
        for (int i = 0; i < bus_seen.size(); i++) begin
            a = bus_seen[i];
            k = int'(a[9]);
            if (!found[k]) begin
                found[k] = 1'b1;
                first_port[k] = int'(a[4]);
            end
        end
        // kinds alternate, ports take turns, each port in FIFO order
        for (int i = 0; i < bus_seen.size(); i++) begin
            k = (i % 2 == 0) ? kind0 : 1 - kind0;
            exp_a = arb_addr(k, (first_port[k] + served[k]) % NUM_HARTS, served[k] / NUM_HARTS);
            served[k]++;
            check_addr("bus_addr", bus_seen[i], exp_a);
        end
    endtask

    task automatic error_path();
        tick();
        post_data(0, WIN_BASE + 32'h10, '0, 4'hf, 1'b0);
        tick();
        drain();
        tick();
        post_fetch(1, 32'h80);
        tick();
        drain();
    endtask

    initial begin
        logic [15:0] a;
        seed            = 32'h7332_4137;
        rst             = 1'b1;
        hold            = 1'b0;
        rand_busy       = 1'b0;
        fetch_req_valid = '0;
        data_req_valid  = '0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            fetch_req[h] = '0;
            data_req[h]  = '0;
            fcred[h]     = CREDITS;
            dcred[h]     = CREDITS;
            fspent[h]    = 0;
            dspent[h]    = 0;
            fret[h]      = 0;
            dret[h]      = 0;
        end
        // same pattern the model loads at start
        for (int i = 0; i < 256; i++) begin
            a = 16'(i * 4);
            shadow[i] = {~a, a};
        end
        repeat (2) @(posedge CLK);
        rst <= 1'b0;
        reset_quiet();
        single_read();
        byte_write();
        credit_flood();
        arbitration_order();
        error_path();
        $display("TEST PASSED");
        $finish;
    end

    // budget of 200 cycles per request
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        fail_now("watchdog ran out, the DUT stopped answering");
    end

endmodule

// File: multicore_mem.f
source/mem_subsys_pkg.sv
source/port_arbiter.sv
source/memory_controller.sv
source/generic_bus_master.sv
source/multicore_mem_top.sv
verification/mem_model.sv
verification/tb_multicore_mem.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_multicore_mem \
    -f multicore_mem.f -o sim_multicore_mem > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_multicore_mem > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
